// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_pkt_replay
FILELIST = pkt_replay_top.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== capture_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// capture engine: writes each beat one 128-bit quarter at a time and
// reads every quarter back, retrying it until the readback matches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module capture_engine (
   input  logic                   clk,
   input  logic                   rst_clk,
   input  logic                   go_i,
   input  replay_pkg::pkt_beat_t  pkt_i,
   input  logic                   pkt_valid_i,
   input  logic                   done_i,
   input  logic                   clear_i,
   input  replay_pkg::app_rsp_t   rsp_i,
   output replay_pkg::app_req_t   req_o,
   output logic                   pkt_ready_o,
   output logic                   busy_o,
   output replay_pkg::word_addr_t end_addr_o
);
   import replay_pkg::*;

   typedef enum logic [1:0] {CAP_IDLE, CAP_WR, CAP_CHECK, CAP_VALID} cap_state_e;

   cap_state_e state_q;
   cap_state_e state_d;
   logic [1:0] quarter_q;
   logic [1:0] quarter_d;
   word_addr_t addr_q;
   word_addr_t addr_d;
   app_data_t  word;
   app_data_t  window;
   app_mask_t  quarter_mask;
   logic       match;

   // beat zero-extended into one memory word
   assign word = app_data_t'(pkt_i);

   // only the current quarter is exposed, on write and on compare
   assign window       = app_data_t'({128{1'b1}}) << {quarter_q, 7'd0};
   assign quarter_mask = ~(app_mask_t'(16'hffff) << {quarter_q, 4'd0});
   assign match        = (rsp_i.rd_data & window) == (word & window);

   assign busy_o = (state_q != CAP_IDLE);

   always_comb begin
      state_d       = state_q;
      quarter_d     = quarter_q;
      addr_d        = addr_q;
      pkt_ready_o   = 1'b0;
      req_o         = '0;
      req_o.addr    = {addr_q, 3'b000};
      req_o.wdf_mask = '1;
      case (state_q)
         CAP_IDLE: begin
            if (go_i) begin
               state_d   = CAP_WR;
               quarter_d = 2'd0;
            end
         end
         CAP_WR: begin
            if (pkt_valid_i) begin
               req_o.cmd      = CMD_WRITE;
               req_o.en       = 1'b1;
               req_o.wdf_end  = 1'b1;
               req_o.wdf_wren = 1'b1;
               req_o.wdf_data = word;
               req_o.wdf_mask = quarter_mask;
               if (rsp_i.wdf_rdy) begin
                  state_d = CAP_CHECK;
               end
            end else if (done_i) begin
               // no beat pending, capture is over
               state_d = CAP_IDLE;
            end
         end
         CAP_CHECK: begin
            req_o.cmd = CMD_READ;
            req_o.en  = 1'b1;
            if (rsp_i.rdy) begin
               state_d = CAP_VALID;
            end
         end
         CAP_VALID: begin
            if (rsp_i.rd_data_valid) begin
               // a mismatch rewrites the same quarter
               state_d = CAP_WR;
               if (match) begin
                  quarter_d = quarter_q + 2'd1;
                  if (quarter_q == 2'd3) begin
                     pkt_ready_o = 1'b1;
                     addr_d      = addr_q + 1'b1;
                  end
               end
            end
         end
         default: state_d = CAP_IDLE;
      endcase
      if (clear_i) begin
         state_d = CAP_IDLE;
         addr_d  = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         state_q    <= CAP_IDLE;
         quarter_q  <= 2'd0;
         addr_q     <= '0;
         end_addr_o <= '0;
      end else begin
         state_q   <= state_d;
         quarter_q <= quarter_d;
         addr_q    <= addr_d;
         if (req_o.en && req_o.wdf_wren && rsp_i.wdf_rdy) begin
            end_addr_o <= addr_q;
         end
      end
   end

endmodule

// ==== ctrl_sync.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control strobe sync: edge pulses plus clear and sw reset hold levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ctrl_sync (
   input  logic                  clk,
   input  logic                  rst_clk,
   input  logic                  sw_rst_i,
   input  logic                  start_replay_i,
   input  logic                  wr_done_i,
   input  replay_pkg::seq_mode_e mode_i,
   output logic                  start_pulse_o,
   output logic                  done_pulse_o,
   output logic                  clear_o,
   output logic                  sw_rst_hold_o
);
   import replay_pkg::*;

   logic [2:0] start_sr;
   logic [2:0] done_sr;
   logic [2:0] swr_sr;
   logic       swr_rise;
   logic       swr_fall;

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         start_sr <= '0;
         done_sr  <= '0;
         swr_sr   <= '0;
      end else begin
         start_sr <= {start_sr[1:0], start_replay_i};
         done_sr  <= {done_sr[1:0], wr_done_i};
         swr_sr   <= {swr_sr[1:0], sw_rst_i};
      end
   end

   // edges taken between stage 2 and stage 3
   assign start_pulse_o = start_sr[1] & ~start_sr[2];
   assign done_pulse_o  = done_sr[1] & ~done_sr[2];
   assign swr_rise      = swr_sr[1] & ~swr_sr[2];
   assign swr_fall      = ~swr_sr[1] & swr_sr[2];

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         clear_o       <= 1'b0;
         sw_rst_hold_o <= 1'b0;
      end else begin
         if (swr_rise) begin
            sw_rst_hold_o <= 1'b1;
         end else if (swr_fall) begin
            sw_rst_hold_o <= 1'b0;
         end
         // clear stays up until the sequencer has gone idle
         if (swr_rise) begin
            clear_o <= 1'b1;
         end else if (mode_i == IDLE) begin
            clear_o <= 1'b0;
         end
      end
   end

endmodule

// ==== dram_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DRAM sequencer: grants the memory port to capture or replay
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dram_sequencer (
   input  logic                  clk,
   input  logic                  rst_clk,
   input  logic                  pkt_valid_i,
   input  logic                  start_i,
   input  logic                  sw_rst_hold_i,
   input  logic                  cap_busy_i,
   input  logic                  rep_busy_i,
   input  replay_pkg::app_req_t  cap_req_i,
   input  replay_pkg::app_req_t  rep_req_i,
   output replay_pkg::seq_mode_e mode_o,
   output logic                  cap_go_o,
   output logic                  rep_go_o,
   output replay_pkg::app_req_t  app_req_o
);
   import replay_pkg::*;

   seq_mode_e mode_d;

   // capture wins over replay, replay is blocked during sw reset
   always_comb begin
      mode_d   = mode_o;
      cap_go_o = 1'b0;
      rep_go_o = 1'b0;
      case (mode_o)
         IDLE: begin
            if (pkt_valid_i) begin
               cap_go_o = 1'b1;
               mode_d   = CAPTURE;
            end else if (start_i && !sw_rst_hold_i) begin
               rep_go_o = 1'b1;
               mode_d   = REPLAY;
            end
         end
         CAPTURE: if (!cap_busy_i) mode_d = IDLE;
         REPLAY:  if (!rep_busy_i) mode_d = IDLE;
         default: mode_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         mode_o <= IDLE;
      end else begin
         mode_o <= mode_d;
      end
   end

   always_comb begin
      case (mode_o)
         CAPTURE: app_req_o = cap_req_i;
         REPLAY:  app_req_o = rep_req_i;
         default: begin
            app_req_o          = '0;
            app_req_o.wdf_mask = '1;
         end
      endcase
   end

endmodule

// ==== pkt_replay_top.f ====
replay_pkg.sv
ctrl_sync.sv
capture_engine.sv
replay_engine.sv
dram_sequencer.sv
reg_bus_slave.sv
pkt_replay_top.sv
tb_dram_model.sv
tb_pkt_replay.sv

// ==== pkt_replay_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet capture and replay controller on a DDR user port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pkt_replay_top #(
   parameter int REPLAY_CNT_W = 32
) (
   input  logic                    clk,
   input  logic                    rst_clk,
   input  replay_pkg::pkt_beat_t   pkt_i,
   input  logic                    pkt_valid_i,
   output logic                    pkt_ready_o,
   input  logic                    ds_ready_i,
   input  logic                    sw_rst_i,
   input  logic                    start_replay_i,
   input  logic                    wr_done_i,
   input  logic [REPLAY_CNT_W-1:0] replay_count_i,
   output replay_pkg::app_req_t    app_req_o,
   input  replay_pkg::app_rsp_t    app_rsp_i,
   input  replay_pkg::bus_req_t    bus_i,
   output replay_pkg::bus_data_t   bus_rdata_o,
   output logic                    bus_rd_ack_o,
   output logic                    bus_wr_ack_o
);
   import replay_pkg::*;

   seq_mode_e  mode;
   logic       start_pulse;
   logic       done_pulse;
   logic       clear;
   logic       sw_rst_hold;
   logic       cap_go;
   logic       rep_go;
   logic       cap_busy;
   logic       rep_busy;
   app_req_t   cap_req;
   app_req_t   rep_req;
   word_addr_t end_addr;

   ctrl_sync u_ctrl_sync (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .sw_rst_i       (sw_rst_i),
      .start_replay_i (start_replay_i),
      .wr_done_i      (wr_done_i),
      .mode_i         (mode),
      .start_pulse_o  (start_pulse),
      .done_pulse_o   (done_pulse),
      .clear_o        (clear),
      .sw_rst_hold_o  (sw_rst_hold)
   );

   capture_engine u_capture_engine (
      .clk         (clk),
      .rst_clk     (rst_clk),
      .go_i        (cap_go),
      .pkt_i       (pkt_i),
      .pkt_valid_i (pkt_valid_i),
      .done_i      (done_pulse),
      .clear_i     (clear),
      .rsp_i       (app_rsp_i),
      .req_o       (cap_req),
      .pkt_ready_o (pkt_ready_o),
      .busy_o      (cap_busy),
      .end_addr_o  (end_addr)
   );

   replay_engine #(
      .REPLAY_CNT_W (REPLAY_CNT_W)
   ) u_replay_engine (
      .clk            (clk),
      .rst_clk        (rst_clk),
      .go_i           (rep_go),
      .start_i        (start_pulse),
      .clear_i        (clear),
      .replay_count_i (replay_count_i),
      .ds_ready_i     (ds_ready_i),
      .end_addr_i     (end_addr),
      .rsp_i          (app_rsp_i),
      .req_o          (rep_req),
      .busy_o         (rep_busy)
   );

   dram_sequencer u_dram_sequencer (
      .clk           (clk),
      .rst_clk       (rst_clk),
      .pkt_valid_i   (pkt_valid_i),
      .start_i       (start_pulse),
      .sw_rst_hold_i (sw_rst_hold),
      .cap_busy_i    (cap_busy),
      .rep_busy_i    (rep_busy),
      .cap_req_i     (cap_req),
      .rep_req_i     (rep_req),
      .mode_o        (mode),
      .cap_go_o      (cap_go),
      .rep_go_o      (rep_go),
      .app_req_o     (app_req_o)
   );

   reg_bus_slave u_reg_bus_slave (
      .clk          (clk),
      .rst_clk      (rst_clk),
      .bus_i        (bus_i),
      .pkt_i        (pkt_i),
      .pkt_valid_i  (pkt_valid_i),
      .cap_go_i     (cap_go),
      .clear_i      (clear),
      .end_addr_i   (end_addr),
      .rsp_i        (app_rsp_i),
      .bus_rdata_o  (bus_rdata_o),
      .bus_rd_ack_o (bus_rd_ack_o),
      .bus_wr_ack_o (bus_wr_ack_o)
   );

endmodule

// ==== reg_bus_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register bus slave: status, packet count and end address readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module reg_bus_slave (
   input  logic                   clk,
   input  logic                   rst_clk,
   input  replay_pkg::bus_req_t   bus_i,
   input  replay_pkg::pkt_beat_t  pkt_i,
   input  logic                   pkt_valid_i,
   input  logic                   cap_go_i,
   input  logic                   clear_i,
   input  replay_pkg::word_addr_t end_addr_i,
   input  replay_pkg::app_rsp_t   rsp_i,
   output replay_pkg::bus_data_t  bus_rdata_o,
   output logic                   bus_rd_ack_o,
   output logic                   bus_wr_ack_o
);
   import replay_pkg::*;

   typedef enum logic [2:0] {
      BUS_IDLE, BUS_WR, BUS_WR_DONE, BUS_WR_WAIT, BUS_RD, BUS_RD_DONE, BUS_RD_WAIT
   } bus_state_e;

   bus_state_e state_q;
   bus_state_e state_d;
   bus_data_t  reg_rdata;
   bus_data_t  pkt_cnt_q;
   logic       tlast_q;
   logic       tlast_rise;

   always_comb begin
      case (bus_i.addr)
         REG_CTRL_STATUS:  reg_rdata = {28'b0, rsp_i.wdf_rdy, rsp_i.rdy, pkt_valid_i,
                                        rsp_i.calib_done};
         REG_PKT_CNT:      reg_rdata = pkt_cnt_q;
         REG_PKT_END_ADDR: reg_rdata = bus_data_t'(end_addr_i);
         default:          reg_rdata = '0;
      endcase
   end

   // ack two cycles after cs, then hold until cs drops
   always_comb begin
      state_d      = BUS_IDLE;
      bus_wr_ack_o = 1'b0;
      bus_rd_ack_o = 1'b0;
      bus_rdata_o  = '0;
      case (state_q)
         BUS_IDLE:    state_d = !bus_i.cs ? BUS_IDLE : (bus_i.rnw ? BUS_RD : BUS_WR);
         BUS_WR:      state_d = BUS_WR_DONE;
         BUS_WR_DONE: begin
            bus_wr_ack_o = 1'b1;
            state_d      = BUS_WR_WAIT;
         end
         BUS_WR_WAIT: state_d = bus_i.cs ? BUS_WR_WAIT : BUS_IDLE;
         BUS_RD:      state_d = BUS_RD_DONE;
         BUS_RD_DONE: begin
            bus_rd_ack_o = 1'b1;
            bus_rdata_o  = reg_rdata;
            state_d      = BUS_RD_WAIT;
         end
         BUS_RD_WAIT: state_d = bus_i.cs ? BUS_RD_WAIT : BUS_IDLE;
         default:     state_d = BUS_IDLE;
      endcase
   end

   assign tlast_rise = pkt_i.tlast && pkt_valid_i && !tlast_q;

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         state_q   <= BUS_IDLE;
         tlast_q   <= 1'b0;
         pkt_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         tlast_q <= pkt_i.tlast && pkt_valid_i;
         // count restarts with every new capture
         if (clear_i || cap_go_i) begin
            pkt_cnt_q <= '0;
         end else if (tlast_rise) begin
            pkt_cnt_q <= pkt_cnt_q + 1'b1;
         end
      end
   end

endmodule

// ==== replay_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// replay engine: reads words 0 to end address for the latched passes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module replay_engine #(
   parameter int REPLAY_CNT_W = 32
) (
   input  logic                    clk,
   input  logic                    rst_clk,
   input  logic                    go_i,
   input  logic                    start_i,
   input  logic                    clear_i,
   input  logic [REPLAY_CNT_W-1:0] replay_count_i,
   input  logic                    ds_ready_i,
   input  replay_pkg::word_addr_t  end_addr_i,
   input  replay_pkg::app_rsp_t    rsp_i,
   output replay_pkg::app_req_t    req_o,
   output logic                    busy_o
);
   import replay_pkg::*;

   typedef enum logic [1:0] {RP_IDLE, RP_READ, RP_WAIT} rep_state_e;

   rep_state_e              state_q;
   word_addr_t              addr_q;
   logic [REPLAY_CNT_W-1:0] count_q;
   logic [REPLAY_CNT_W-1:0] pass_q;
   logic [REPLAY_CNT_W-1:0] passes_max;
   logic                    issue;

   // a zero count still gives one pass
   assign passes_max = (count_q == '0) ? REPLAY_CNT_W'(1) : count_q;
   assign issue      = (state_q == RP_READ) && ds_ready_i && rsp_i.rdy;
   assign busy_o     = (state_q != RP_IDLE);

   always_comb begin
      req_o          = '0;
      req_o.addr     = {addr_q, 3'b000};
      req_o.cmd      = CMD_READ;
      req_o.en       = issue;
      req_o.wdf_mask = '1;
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         state_q <= RP_IDLE;
         addr_q  <= '0;
         pass_q  <= '0;
         count_q <= '0;
      end else begin
         if (clear_i) begin
            count_q <= '0;
         end else if (start_i) begin
            count_q <= replay_count_i;
         end
         if (clear_i) begin
            state_q <= RP_IDLE;
         end else begin
            case (state_q)
               RP_IDLE: begin
                  if (go_i) begin
                     state_q <= RP_READ;
                     addr_q  <= '0;
                     pass_q  <= '0;
                  end
               end
               RP_READ: begin
                  if (issue) begin
                     addr_q <= addr_q + 1'b1;
                     if (addr_q == end_addr_i) begin
                        pass_q  <= pass_q + 1'b1;
                        state_q <= RP_WAIT;
                     end
                  end
               end
               RP_WAIT: begin
                  addr_q  <= '0;
                  state_q <= (pass_q < passes_max) ? RP_READ : RP_IDLE;
               end
               default: state_q <= RP_IDLE;
            endcase
         end
      end
   end

endmodule

// ==== replay_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet replay package: widths, bus and memory port types, constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package replay_pkg;

   localparam int WORD_ADDR_W = 27;
   localparam int APP_ADDR_W  = 30;

   typedef logic [WORD_ADDR_W-1:0] word_addr_t;
   // word address followed by three zero bits
   typedef logic [APP_ADDR_W-1:0]  app_addr_t;
   typedef logic [511:0]           app_data_t;
   typedef logic [63:0]            app_mask_t;
   typedef logic [2:0]             app_cmd_t;
   typedef logic [31:0]            bus_data_t;

   localparam app_cmd_t CMD_WRITE = 3'd0;
   localparam app_cmd_t CMD_READ  = 3'd1;

   typedef struct packed {
      logic [255:0] tdata;
      logic [31:0]  tkeep;
      logic [127:0] tuser;
      logic         tlast;
   } pkt_beat_t;

   // user-port request, a set mask bit hides that byte
   typedef struct packed {
      app_addr_t addr;
      app_cmd_t  cmd;
      logic      en;
      app_data_t wdf_data;
      logic      wdf_end;
      logic      wdf_wren;
      app_mask_t wdf_mask;
   } app_req_t;

   typedef struct packed {
      logic      rdy;
      logic      wdf_rdy;
      app_data_t rd_data;
      logic      rd_data_valid;
      logic      calib_done;
   } app_rsp_t;

   typedef struct packed {
      logic [15:0] addr;
      logic        cs;
      logic        rnw;
      bus_data_t   data;
   } bus_req_t;

   localparam logic [15:0] REG_CTRL_STATUS  = 16'h0000;
   localparam logic [15:0] REG_PKT_CNT      = 16'h0004;
   localparam logic [15:0] REG_PKT_END_ADDR = 16'h0008;

   typedef enum logic [1:0] {IDLE, CAPTURE, REPLAY} seq_mode_e;

endpackage

// ==== tb_dram_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDR user-port model: masked writes, delayed reads, random stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_dram_model (
   input  logic                 clk,
   input  logic                 rst_clk,
   input  logic                 stall_en_i,
   input  logic                 corrupt_i,
   input  replay_pkg::app_req_t req_i,
   output replay_pkg::app_rsp_t rsp_o
);
   import replay_pkg::*;

   localparam int DEPTH = 64;

   app_data_t mem [DEPTH];
   app_data_t rd_q [$];
   longint    due_q [$];
   longint    cycle;
   longint    last_due;
   longint    due;
   logic      corrupt_pend;
   app_data_t merged;
   app_data_t data;
   int        idx;

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = {16{32'hc0de0000 | i}};
      end
   end

   assign idx = int'(req_i.addr[3 +: 6]);

   always @(posedge clk) begin
      if (rst_clk) begin
         rsp_o        <= '0;
         cycle        = 0;
         last_due     = 0;
         corrupt_pend = 1'b0;
         rd_q.delete();
         due_q.delete();
      end else begin
         cycle++;
         if (corrupt_i) begin
            corrupt_pend = 1'b1;
         end
         // a set mask bit keeps the stored byte
         if (req_i.en && req_i.cmd == CMD_WRITE && req_i.wdf_wren && rsp_o.wdf_rdy) begin
            merged = mem[idx];
            for (int b = 0; b < 64; b++) begin
               if (!req_i.wdf_mask[b]) begin
                  merged[b*8 +: 8] = req_i.wdf_data[b*8 +: 8];
               end
            end
            mem[idx] <= merged;
         end
         if (req_i.en && req_i.cmd == CMD_READ && rsp_o.rdy) begin
            // returns stay in order
            due      = cycle + 2 + $urandom % 4;
            last_due = (due > last_due) ? due : last_due + 1;
            rd_q.push_back(mem[idx]);
            due_q.push_back(last_due);
         end
         if (due_q.size() > 0 && cycle >= due_q[0]) begin
            data = rd_q.pop_front();
            void'(due_q.pop_front());
            if (corrupt_pend) begin
               data         = ~data;
               corrupt_pend = 1'b0;
            end
            rsp_o.rd_data       <= data;
            rsp_o.rd_data_valid <= 1'b1;
         end else begin
            rsp_o.rd_data_valid <= 1'b0;
         end
         rsp_o.calib_done <= 1'b1;
         rsp_o.rdy        <= !stall_en_i || ($urandom % 4 != 0);
         rsp_o.wdf_rdy    <= !stall_en_i || ($urandom % 4 != 0);
      end
   end

endmodule

// ==== tb_pkt_replay.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the packet capture and replay controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_pkt_replay;
   import replay_pkg::*;

   localparam int NUM_BEATS     = 20;
   localparam int CORRUPT_BEAT  = 7;
   localparam int REPLAY_PASSES = 3;
   localparam int CLK_PERIOD    = 20;
   localparam int WAIT_LIMIT    = 2000;
   // about 400 cycles per beat worst case, plus replay and bus traffic
   localparam int WATCHDOG_TIME = 10000 * CLK_PERIOD;

   logic        clk;
   logic        rst_clk;
   pkt_beat_t   pkt;
   logic        pkt_valid;
   logic        pkt_ready;
   logic        ds_ready = 1'b1;
   logic        sw_rst;
   logic        start_replay;
   logic        wr_done;
   logic [31:0] replay_count;
   app_req_t    app_req;
   app_rsp_t    app_rsp;
   bus_req_t    bus;
   bus_data_t   bus_rdata;
   logic        bus_rd_ack;
   logic        bus_wr_ack;
   logic        stall_en;
   logic        corrupt;
   logic        in_replay;
   pkt_beat_t   beats [NUM_BEATS];
   app_addr_t   rd_addrs [$];
   int          wr_cmds;
   int          exp_pkts;
   bus_data_t   rdata;

   pkt_replay_top #(.REPLAY_CNT_W(32)) DUT (
      .clk(clk), .rst_clk(rst_clk), .pkt_i(pkt), .pkt_valid_i(pkt_valid),
      .pkt_ready_o(pkt_ready), .ds_ready_i(ds_ready), .sw_rst_i(sw_rst),
      .start_replay_i(start_replay), .wr_done_i(wr_done), .replay_count_i(replay_count),
      .app_req_o(app_req), .app_rsp_i(app_rsp), .bus_i(bus), .bus_rdata_o(bus_rdata),
      .bus_rd_ack_o(bus_rd_ack), .bus_wr_ack_o(bus_wr_ack)
   );

   tb_dram_model u_mem (
      .clk(clk), .rst_clk(rst_clk), .stall_en_i(stall_en), .corrupt_i(corrupt),
      .req_i(app_req), .rsp_o(app_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
   endtask

   task automatic report_timeout(input string msg);
      $display("timeout at %0t: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped");
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   // exactly one 16-byte quarter left unmasked
   function automatic logic single_quarter(input app_mask_t m);
      logic ok;
      ok = 1'b0;
      for (int q = 0; q < 4; q++) begin
         if (~m == (app_mask_t'(16'hffff) << (16 * q))) ok = 1'b1;
      end
      return ok;
   endfunction

   function automatic pkt_beat_t random_beat(input logic last);
      logic [447:0] raw;
      pkt_beat_t    b;
      for (int i = 0; i < 14; i++) raw[i*32 +: 32] = $urandom;
      b       = pkt_beat_t'(raw[$bits(pkt_beat_t)-1:0]);
      b.tlast = last;
      return b;
   endfunction

   // random downstream stalls while replay is under test
   always @(posedge clk) begin
      ds_ready <= in_replay ? ($urandom % 3 != 0) : 1'b1;
   end

   always @(posedge clk) begin
      if (!rst_clk && app_req.en) begin
         if (app_req.cmd == CMD_WRITE && app_req.wdf_wren) begin
            assert (single_quarter(app_req.wdf_mask))
               else report_mismatch("write mask exposes more than one quarter");
            assert (app_req.wdf_end) else report_mismatch("write command without wdf_end");
            if (app_rsp.wdf_rdy) wr_cmds++;
         end
         if (app_req.cmd == CMD_READ && in_replay) begin
            assert (ds_ready) else report_mismatch("replay read issued with ds_ready low");
            if (app_rsp.rdy) rd_addrs.push_back(app_req.addr);
         end
      end
      if (!rst_clk && pkt_ready) begin
         assert (pkt_valid) else report_mismatch("pkt_ready pulse with no beat pending");
      end
   end

   task automatic bus_access(input logic [15:0] addr, input logic rnw, output bus_data_t data);
      int acks;
      int waited;
      acks   = 0;
      waited = 0;
      @(posedge clk);
      bus.addr <= addr;
      bus.rnw  <= rnw;
      bus.data <= 32'h5a5a0000 | addr;
      bus.cs   <= 1'b1;
      do begin
         @(posedge clk);
         waited++;
         if (waited > 50) report_timeout("register bus access got no ack");
         if (bus_rd_ack || bus_wr_ack) acks++;
      end while (!(rnw ? bus_rd_ack : bus_wr_ack));
      data = bus_rdata;
      repeat (4) begin
         @(posedge clk);
         if (bus_rd_ack || bus_wr_ack) acks++;
      end
      bus.cs <= 1'b0;
      wait_cycles(3);
      assert (acks == 1) else report_mismatch("bus access not acked exactly once");
   endtask

   task automatic send_beat(input pkt_beat_t beat, input logic inject, input int word);
      int waited;
      waited = 0;
      @(posedge clk);
      wr_cmds = 0;
      pkt       <= beat;
      pkt_valid <= 1'b1;
      corrupt   <= inject;
      do begin
         @(posedge clk);
         corrupt <= 1'b0;
         waited++;
         if (waited > WAIT_LIMIT) report_timeout("beat was never consumed");
      end while (!pkt_ready);
      pkt_valid <= 1'b0;
      assert (u_mem.mem[word] == app_data_t'(beat))
         else report_mismatch($sformatf("memory word %0d differs from its beat", word));
      if (inject) begin
         assert (wr_cmds > 4) else report_mismatch("corrupted beat was not rewritten");
      end else begin
         assert (wr_cmds == 4) else report_mismatch($sformatf("beat took %0d writes", wr_cmds));
      end
   endtask

   // start_replay when start is set, wr_done otherwise
   task automatic pulse_strobe(input logic start);
      if (start) begin
         start_replay <= 1'b1;
      end else begin
         wr_done <= 1'b1;
      end
      wait_cycles(4);
      start_replay <= 1'b0;
      wr_done      <= 1'b0;
   endtask

   initial begin
      void'($urandom(385));
      rst_clk      = 1'b1;
      pkt          = '0;
      pkt_valid    = 1'b0;
      sw_rst       = 1'b0;
      start_replay = 1'b0;
      wr_done      = 1'b0;
      replay_count = '0;
      bus          = '0;
      stall_en     = 1'b0;
      corrupt      = 1'b0;
      in_replay    = 1'b0;
      wr_cmds      = 0;
      exp_pkts     = 0;
      wait_cycles(10);
      rst_clk <= 1'b0;
      wait_cycles(5);

      // status is calib, valid, rdy, wdf_rdy from bit 0 up
      bus_access(REG_CTRL_STATUS, 1'b1, rdata);
      assert (rdata == 32'hd) else report_mismatch("status register after reset");
      bus_access(REG_PKT_CNT, 1'b1, rdata);
      assert (rdata == 0) else report_mismatch("packet count not zero after reset");
      bus_access(REG_PKT_END_ADDR, 1'b1, rdata);
      assert (rdata == 0) else report_mismatch("end address not zero after reset");
      bus_access(REG_PKT_CNT, 1'b0, rdata);

      // the first beat starts capture and would lose its tlast to the count reset
      stall_en <= 1'b1;
      for (int i = 0; i < NUM_BEATS; i++) begin
         beats[i] = random_beat(i != 0 && $urandom % 2 == 1);
         if (beats[i].tlast) exp_pkts++;
         send_beat(beats[i], i == CORRUPT_BEAT, i);
         wait_cycles(1 + $urandom % 3);
      end

      pulse_strobe(1'b0);
      wait_cycles(10);
      bus_access(REG_PKT_CNT, 1'b1, rdata);
      assert (rdata == exp_pkts) else report_mismatch("packet count after capture");
      bus_access(REG_PKT_END_ADDR, 1'b1, rdata);
      assert (rdata == NUM_BEATS - 1) else report_mismatch("end address after capture");

      replay_count <= REPLAY_PASSES;
      in_replay    <= 1'b1;
      pulse_strobe(1'b1);
      for (int w = 0; rd_addrs.size() < NUM_BEATS * REPLAY_PASSES; w++) begin
         if (w > WAIT_LIMIT) report_timeout("replay reads did not complete");
         @(posedge clk);
      end
      wait_cycles(40);
      assert (rd_addrs.size() == NUM_BEATS * REPLAY_PASSES)
         else report_mismatch($sformatf("replay issued %0d reads", rd_addrs.size()));
      for (int i = 0; i < NUM_BEATS * REPLAY_PASSES; i++) begin
         assert (rd_addrs[i] == app_addr_t'((i % NUM_BEATS) << 3))
            else report_mismatch($sformatf("replay read %0d at wrong address", i));
      end
      in_replay <= 1'b0;
      wait_cycles(2);

      // replay must stay blocked while sw_rst is high
      rd_addrs.delete();
      sw_rst <= 1'b1;
      wait_cycles(8);
      in_replay <= 1'b1;
      pulse_strobe(1'b1);
      wait_cycles(30);
      assert (rd_addrs.size() == 0) else report_mismatch("replay ran during sw reset");
      in_replay <= 1'b0;
      sw_rst    <= 1'b0;
      wait_cycles(8);
      send_beat(random_beat(1'b0), 1'b0, 0);
      wait_cycles(2);
      send_beat(random_beat(1'b1), 1'b0, 1);
      pulse_strobe(1'b0);
      wait_cycles(10);

      $display("NO ERRORS");
      $finish;
   end

   initial begin
      #(WATCHDOG_TIME);
      report_timeout("watchdog expired before the tests completed");
   end

endmodule
